// File: files.f
+incdir+common
common/trafficPkg.sv
common/laneTablePkg.sv
lane/laneMotion.sv
lane/carHitDetect.sv
source/trafficGenerator.sv
bench/laneMotion_sva.sv
bench/trafficGenerator_tb.sv

// File: Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and check $(LOG)"
	@echo "  clean  remove the build directory and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f files.f \
		--top-module trafficGenerator_tb -Mdir obj_dir
	-./obj_dir/VtrafficGenerator_tb > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "^Testbench passed$$" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// File: bench/trafficGenerator_tb.sv
`include "traffic_config.svh"

module trafficGenerator_tb
	import trafficPkg::*;
	import laneTablePkg::*;
;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int resetCycles = 4;
	localparam int maskCycles = 500;
	localparam int motionCycles = 1000;
	localparam int wrapCycles = 700;
	// start probes are bounded by the slot count of the whole table
	localparam int testCycles = 2 * (resetCycles + 1 + `LANE_COUNT * `MAX_SLOTS)
		+ maskCycles + motionCycles + wrapCycles;
	localparam int cycleLimit = testCycles + testCycles / 5;

	logic update;
	logic rst;
	logic moveTick;
	coordX xCount;
	coordY yCount;
	logic [`TRAFFIC_WIDTH-1:0] traffic;

	logic [16:0] lfsr;
	int modelX [`LANE_COUNT][`MAX_SLOTS];
	logic [`TRAFFIC_WIDTH-1:0] disabledMask;
	int cycleCount;

	trafficGenerator u_dut (
		.update(update),
		.rst(rst),
		.moveTick(moveTick),
		.xCount(xCount),
		.yCount(yCount),
		.traffic(traffic)
	);

	bind laneMotion laneMotion_sva #(
		.laneIndex(laneIndex)
	) u_sva (
		.update(update),
		.rst(rst),
		.moveTick(moveTick),
		.carX(carX)
	);

	initial
	begin
		update = 1'b0;
		forever #4 update = ~update;
	end

	// taps of x^17 + x^14 + 1 with one step per bit taken
	function automatic int randBits(input int count);
		int value;
		logic feedback;
		value = 0;
		for (int i = 0; i < count; i++)
		begin
			feedback = lfsr[16] ^ lfsr[13];
			lfsr = {lfsr[15:0], feedback};
			value = (value << 1) | int'(feedback);
		end
		return value;
	endfunction

	function automatic void loadStarts();
		for (int l = 0; l < `LANE_COUNT; l++)
			for (int s = 0; s < `MAX_SLOTS; s++)
				modelX[l][s] = int'(laneTable[l].start[s]);
	endfunction

	function automatic void advanceModel();
		int speed;
		for (int l = 0; l < `LANE_COUNT; l++)
		begin
			speed = int'(laneTable[l].speed);
			for (int s = 0; s < `MAX_SLOTS; s++)
			begin
				if (laneTable[l].enable[s])
				begin
					if (laneTable[l].dir == moveRight)
						modelX[l][s] = (modelX[l][s] >= `SCREEN_WIDTH) ? 0
							: modelX[l][s] + speed;
					else
						modelX[l][s] = (modelX[l][s] == 0) ? `SCREEN_WIDTH
							: modelX[l][s] - speed;
				end
			end
		end
	endfunction

	// strict inequalities keep the window border outside the car
	function automatic logic [`TRAFFIC_WIDTH-1:0] modelTraffic(input int x, input int y);
		logic [`TRAFFIC_WIDTH-1:0] hits;
		int row;
		hits = '0;
		for (int l = 0; l < `LANE_COUNT; l++)
		begin
			row = int'(laneTable[l].row);
			for (int s = 0; s < int'(laneTable[l].slotCount); s++)
			begin
				if (laneTable[l].enable[s] && y > row && y < row + `CAR_SIZE
					&& x > modelX[l][s] && x < modelX[l][s] + `CAR_SIZE)
					hits[int'(laneTable[l].slotBase) + s] = 1'b1;
			end
		end
		return hits;
	endfunction

	function automatic logic [`TRAFFIC_WIDTH-1:0] buildDisabledMask();
		logic [`TRAFFIC_WIDTH-1:0] mask;
		mask = '0;
		for (int l = 0; l < `LANE_COUNT; l++)
			for (int s = 0; s < int'(laneTable[l].slotCount); s++)
				if (!laneTable[l].enable[s])
					mask[int'(laneTable[l].slotBase) + s] = 1'b1;
		return mask;
	endfunction

	task automatic checkValue(input string testName, input logic [`TRAFFIC_WIDTH-1:0] expected,
		input logic [`TRAFFIC_WIDTH-1:0] actual);
		if (actual !== expected)
		begin
			$display("CHECK FAILED %s expected %h actual %h", testName, expected, actual);
			$display("Testbench failed");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	// entered and left on a falling edge
	task automatic runCycle(input logic tick, input coordX x, input coordY y,
		input string testName);
		logic [`TRAFFIC_WIDTH-1:0] expected;
		moveTick = tick;
		xCount = x;
		yCount = y;
		expected = modelTraffic(int'(x), int'(y));
		if (tick)
			advanceModel();
		@(negedge update);
		checkValue(testName, expected, traffic);
	endtask

	task automatic applyReset();
		rst = 1'b1;
		moveTick = 1'b0;
		// pixel inside the first start window while reset is held
		xCount = coordX'(int'(laneTable[0].start[0]) + 8);
		yCount = coordY'(int'(laneTable[0].row) + 8);
		repeat (resetCycles) @(posedge update);
		@(negedge update);
		rst = 1'b0;
		loadStarts();
		checkValue("traffic cleared by reset", '0, traffic);
	endtask

	task automatic probeStarts(input string testName);
		int bitIndex;
		logic [`TRAFFIC_WIDTH-1:0] oneHot;
		for (int l = 0; l < `LANE_COUNT; l++)
		begin
			for (int s = 0; s < `MAX_SLOTS; s++)
			begin
				if (laneTable[l].enable[s])
				begin
					runCycle(1'b0, coordX'(int'(laneTable[l].start[s]) + 8),
						coordY'(int'(laneTable[l].row) + 8), testName);
					bitIndex = int'(laneTable[l].slotBase) + s;
					oneHot = '0;
					oneHot[bitIndex] = 1'b1;
					checkValue(testName, oneHot, traffic);
				end
			end
		end
	endtask

	// three out of four pixels land in or next to a lane row
	task automatic pickPixel(output coordX x, output coordY y);
		int lane;
		if (randBits(2) != 0)
		begin
			lane = randBits(4) % `LANE_COUNT;
			y = coordY'(int'(laneTable[lane].row) + randBits(5) % 19);
		end
		else
			y = coordY'(randBits(10));
		x = coordX'(randBits(10));
	endtask

	task automatic pickEdgeProbe(output coordX x, output coordY y);
		int lane;
		int slot;
		do
		begin
			lane = randBits(4) % `LANE_COUNT;
			slot = randBits(4) % `MAX_SLOTS;
		end
		while (!laneTable[lane].enable[slot]);
		y = coordY'(int'(laneTable[lane].row) + 1 + randBits(4));
		if (randBits(1) != 0)
			x = coordX'(modelX[lane][slot] + 1 + randBits(4));
		else if (randBits(1) != 0)
			x = coordX'(randBits(5));
		else
			x = coordX'(608 + randBits(6));
	endtask

	initial
	begin
		cycleCount = 0;
		while (cycleCount <= cycleLimit)
		begin
			@(posedge update);
			cycleCount++;
		end
		$display("timeout: the tests did not finish within %0d cycles", cycleLimit);
		$display("Testbench failed");
		$fatal(1, "run stopped by the cycle limit");
	end

	initial
	begin
		coordX x;
		coordY y;
		lfsr = 17'd71035;
		rst = 1'b1;
		moveTick = 1'b0;
		xCount = '0;
		yCount = '0;
		disabledMask = buildDisabledMask();

		applyReset();
		probeStarts("reset start windows");

		repeat (maskCycles)
		begin
			pickPixel(x, y);
			runCycle(logic'(randBits(1)), x, y, "masked slots");
			checkValue("masked slots stay low", '0, traffic & disabledMask);
		end

		repeat (motionCycles)
		begin
			pickPixel(x, y);
			runCycle(logic'(randBits(1)), x, y, "random motion");
		end

		// long enough for every lane to cross an edge
		repeat (wrapCycles)
		begin
			pickEdgeProbe(x, y);
			runCycle(1'b1, x, y, "wrap at screen edges");
		end

		applyReset();
		probeStarts("start windows after mid-run reset");

		$display("Testbench passed");
		$finish;
	end

endmodule

// File: bench/laneMotion_sva.sv
`include "traffic_config.svh"

module laneMotion_sva
	import trafficPkg::*;
	import laneTablePkg::*;
#(
	parameter int laneIndex = 0
)
(
	input logic update,
	input logic rst,
	input logic moveTick,
	input coordX carX [`MAX_SLOTS]
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam laneInfo lane = laneTable[laneIndex];
	// a right-moving car may overshoot the edge by less than one step before it wraps
	localparam int xLimit = `SCREEN_WIDTH + int'(lane.speed) - 1;

	for (genvar i = 0; i < `MAX_SLOTS; i++)
	begin : slots
		localparam coordX startX = lane.start[i];

		inRange: assert property (@(posedge update) disable iff (rst)
			int'(carX[i]) <= xLimit)
			else $error("lane %0d slot %0d position %0d is past the screen edge",
				laneIndex, i, carX[i]);

		holdWithoutTick: assert property (@(posedge update)
			(!rst && !moveTick) |=> $stable(carX[i]))
			else $error("lane %0d slot %0d moved without a move tick", laneIndex, i);

		startAfterReset: assert property (@(posedge update)
			rst |=> carX[i] == startX)
			else $error("lane %0d slot %0d did not load its start position", laneIndex, i);
	end

endmodule

// File: source/trafficGenerator.sv
`include "traffic_config.svh"

module trafficGenerator
	import trafficPkg::*;
	import laneTablePkg::*;
(
	input logic update,
	input logic rst,
	input logic moveTick,
	input coordX xCount,
	input coordY yCount,
	output logic [`TRAFFIC_WIDTH-1:0] traffic
);

	// one motion block and one hit block per lane
	for (genvar l = 0; l < `LANE_COUNT; l++)
	begin : lanes
		localparam int laneBase = int'(laneTable[l].slotBase);
		localparam int laneSlots = int'(laneTable[l].slotCount);

		coordX carX [`MAX_SLOTS];
		slotMask laneHits;

		laneMotion #(
			.laneIndex(l)
		) u_motion (
			.update(update),
			.rst(rst),
			.moveTick(moveTick),
			.carX(carX)
		);

		carHitDetect #(
			.laneIndex(l)
		) u_hit (
			.update(update),
			.rst(rst),
			.xCount(xCount),
			.yCount(yCount),
			.carX(carX),
			.laneHits(laneHits)
		);

		// slot bases are back to back, so the lanes tile the whole vector
		assign traffic[laneBase +: laneSlots] = laneHits[laneSlots-1:0];
	end

endmodule

// File: lane/carHitDetect.sv
`include "traffic_config.svh"

module carHitDetect
	import trafficPkg::*;
	import laneTablePkg::*;
#(
	parameter int laneIndex = 0
)
(
	input logic update,
	input logic rst,
	input coordX xCount,
	input coordY yCount,
	input coordX carX [`MAX_SLOTS],
	output slotMask laneHits
);

	localparam laneInfo lane = laneTable[laneIndex];
	localparam coordY rowTop = lane.row;
	localparam coordY rowBottom = coordY'(lane.row + `CAR_SIZE);

	logic inRow;
	coordX carRight [`MAX_SLOTS];
	slotMask hitNow;

	// the window is open on all four sides, edge pixels do not count
	always_comb
	begin
		inRow = (yCount > rowTop) && (yCount < rowBottom);
		for (int i = 0; i < `MAX_SLOTS; i++)
		begin
			carRight[i] = carX[i] + coordX'(`CAR_SIZE);
			hitNow[i] = inRow && (xCount > carX[i]) && (xCount < carRight[i]);
		end
	end

	// one cycle from pixel to hit bit, unused slots stay low
	always_ff @(posedge update)
	begin
		if (rst)
			laneHits <= '0;
		else
			laneHits <= hitNow & lane.enable;
	end

endmodule

// File: lane/laneMotion.sv
`include "traffic_config.svh"

module laneMotion
	import trafficPkg::*;
	import laneTablePkg::*;
#(
	parameter int laneIndex = 0
)
(
	input logic update,
	input logic rst,
	input logic moveTick,
	output coordX carX [`MAX_SLOTS]
);

	localparam laneInfo lane = laneTable[laneIndex];
	localparam coordX step = coordX'(lane.speed);
	localparam coordX screenEdge = coordX'(`SCREEN_WIDTH);

	coordX nextX [`MAX_SLOTS];

	// position after one move step, every car wraps on its own
	always_comb
	begin
		for (int i = 0; i < `MAX_SLOTS; i++)
		begin
			if (lane.dir == moveRight)
			begin
				// past the right edge the car comes back in at the left
				if (carX[i] >= screenEdge)
					nextX[i] = '0;
				else
					nextX[i] = carX[i] + step;
			end
			else
			begin
				// left edge reached, restart just off the right edge
				if (carX[i] == '0)
					nextX[i] = screenEdge;
				else
					nextX[i] = carX[i] - step;
			end
		end
	end

	// disabled slots load zero on reset and are never stepped
	always_ff @(posedge update)
	begin
		for (int i = 0; i < `MAX_SLOTS; i++)
		begin
			if (rst)
				carX[i] <= lane.start[i];
			else if (moveTick && lane.enable[i])
				carX[i] <= nextX[i];
		end
	end

endmodule

// File: common/laneTablePkg.sv
`include "traffic_config.svh"

package laneTablePkg;

	import trafficPkg::*;

	// everything that describes one lane of level 1
	typedef struct packed
	{
		coordY row;
		laneSpeed speed;
		laneDir dir;
		slotBaseIdx slotBase;
		slotCountVal slotCount;
		slotMask enable;
		coordX [0:`MAX_SLOTS-1] start;
	} laneInfo;

	// index 0 is the top lane
	// disabled slots carry a start of zero and never move
	localparam laneInfo laneTable [`LANE_COUNT] = '{
		'{
			row: 10'd74, speed: 2'd1, dir: moveRight,
			slotBase: 7'd0, slotCount: 4'd10, enable: 13'b0001111111111,
			start: '{20, 90, 160, 230, 300, 370, 440, 510, 580, 610, 0, 0, 0}
		},
		'{
			row: 10'd99, speed: 2'd2, dir: moveRight,
			slotBase: 7'd10, slotCount: 4'd11, enable: 13'b0000101010101,
			start: '{20, 0, 160, 0, 300, 0, 440, 0, 580, 0, 0, 0, 0}
		},
		'{
			row: 10'd124, speed: 2'd2, dir: moveLeft,
			slotBase: 7'd21, slotCount: 4'd9, enable: 13'b0000011011011,
			start: '{30, 100, 0, 240, 310, 0, 450, 520, 0, 0, 0, 0, 0}
		},
		// empty in level 1
		'{
			row: 10'd149, speed: 2'd1, dir: moveRight,
			slotBase: 7'd30, slotCount: 4'd6, enable: 13'b0000000000000,
			start: '{default: 0}
		},
		'{
			row: 10'd174, speed: 2'd1, dir: moveLeft,
			slotBase: 7'd36, slotCount: 4'd9, enable: 13'b0000110110110,
			start: '{0, 90, 160, 0, 300, 370, 0, 510, 580, 0, 0, 0, 0}
		},
		// slots 10 and 12 start out of order, they fill the gaps of the lane
		'{
			row: 10'd199, speed: 2'd2, dir: moveLeft,
			slotBase: 7'd45, slotCount: 4'd13, enable: 13'b1011101101101,
			start: '{20, 0, 160, 230, 0, 370, 440, 0, 580, 610, 470, 0, 130}
		},
		'{
			row: 10'd224, speed: 2'd1, dir: moveRight,
			slotBase: 7'd58, slotCount: 4'd7, enable: 13'b0000001111111,
			start: '{20, 115, 200, 310, 415, 570, 495, 0, 0, 0, 0, 0, 0}
		},
		// empty in level 1
		'{
			row: 10'd249, speed: 2'd1, dir: moveRight,
			slotBase: 7'd65, slotCount: 4'd1, enable: 13'b0000000000000,
			start: '{default: 0}
		},
		'{
			row: 10'd274, speed: 2'd1, dir: moveRight,
			slotBase: 7'd66, slotCount: 4'd6, enable: 13'b0000000111111,
			start: '{30, 150, 255, 365, 465, 570, 0, 0, 0, 0, 0, 0, 0}
		},
		'{
			row: 10'd299, speed: 2'd2, dir: moveRight,
			slotBase: 7'd72, slotCount: 4'd10, enable: 13'b0000110111101,
			start: '{10, 0, 130, 190, 250, 315, 0, 440, 510, 0, 0, 0, 0}
		},
		'{
			row: 10'd324, speed: 2'd1, dir: moveLeft,
			slotBase: 7'd82, slotCount: 4'd9, enable: 13'b0000111111111,
			start: '{30, 100, 170, 240, 310, 385, 450, 520, 580, 0, 0, 0, 0}
		},
		'{
			row: 10'd349, speed: 2'd2, dir: moveLeft,
			slotBase: 7'd91, slotCount: 4'd6, enable: 13'b0000000111111,
			start: '{20, 110, 210, 330, 450, 570, 0, 0, 0, 0, 0, 0, 0}
		},
		// empty in level 1
		'{
			row: 10'd374, speed: 2'd1, dir: moveRight,
			slotBase: 7'd97, slotCount: 4'd6, enable: 13'b0000000000000,
			start: '{default: 0}
		},
		'{
			row: 10'd399, speed: 2'd2, dir: moveLeft,
			slotBase: 7'd103, slotCount: 4'd5, enable: 13'b0000000011111,
			start: '{24, 150, 290, 440, 570, 0, 0, 0, 0, 0, 0, 0, 0}
		},
		// bottom lane, closest to the player start
		'{
			row: 10'd424, speed: 2'd1, dir: moveLeft,
			slotBase: 7'd108, slotCount: 4'd7, enable: 13'b0000001011101,
			start: '{20, 0, 200, 310, 415, 0, 495, 0, 0, 0, 0, 0, 0}
		}
	};

endpackage

// File: common/trafficPkg.sv
`include "traffic_config.svh"

package trafficPkg;

	// pixel coordinates as counted by the video timing
	typedef logic [9:0] coordX;
	typedef logic [9:0] coordY;

	// pixels moved per move step
	typedef logic [1:0] laneSpeed;

	// direction of travel, shared by every car of a lane
	typedef enum logic
	{
		moveRight,
		moveLeft
	} laneDir;

	// one bit per car slot of a lane, bit 0 is slot 0
	typedef logic [`MAX_SLOTS-1:0] slotMask;

	// slot position inside the traffic vector
	typedef logic [6:0] slotBaseIdx;

	// number of slots a lane owns in the traffic vector
	typedef logic [3:0] slotCountVal;

endpackage

// File: common/traffic_config.svh
`ifndef TRAFFIC_CONFIG_SVH
`define TRAFFIC_CONFIG_SVH

// visible screen width in pixels
// cars moving right wrap once they reach it, cars moving left reappear there
`define SCREEN_WIDTH 640

// side of the square car window in pixels
`define CAR_SIZE 17

// one traffic bit per car slot over all lanes
`define TRAFFIC_WIDTH 115

// horizontal lanes from the top of the road down
`define LANE_COUNT 15

// slot count of the widest lane
`define MAX_SLOTS 13

`endif
